//--- design/oled_init.mem
// SSD1331 power-up command bytes in hex, one per line, sent in order with dc low.
// Column 1 is the byte. The remark after it names the command.
AE  // Display off.
A0  // Remap and color depth.
72
A1  // Display start line.
00
A2  // Display offset.
00
A8  // Multiplex ratio, 64 rows.
3F
AD  // Master configuration.
8E
B0  // Power save mode.
0B
B1  // Phase 1 and 2 periods.
31
87  // Master current.
06
AF  // Display on.

//--- compile.f
design/mouse_oled_pkg.sv
design/ps2_byte_if.sv
design/ps2_line_ctrl.sv
design/mouse_packet_decoder.sv
design/oled_frame_streamer.sv
design/mouse_oled_top.sv
bench/ps2_mouse_model.sv
bench/tb_mouse_oled.sv

//--- bench/tb_mouse_oled.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mouse_oled;

  localparam int FIXED_ROWS     = 10;
  localparam int FILLER_ROWS    = 4;
  localparam int NUM_ROWS       = FIXED_ROWS + FILLER_ROWS;
  localparam int FRAME_WORDS    = mouse_oled_pkg::OLED_WIDTH * mouse_oled_pkg::OLED_HEIGHT;
  localparam int FRAME_BYTES    = FRAME_WORDS * 2;
  localparam int FRAME_CYCLES   = FRAME_BYTES * 16;
  localparam int INIT_CYCLES    = 16 + mouse_oled_pkg::OLED_RESET_CYCLES
                                + mouse_oled_pkg::INIT_LENGTH * 16
                                + mouse_oled_pkg::PS2_INHIBIT_CYCLES + 2000;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 600 + 3 * FRAME_CYCLES + INIT_CYCLES;

  logic                      clk;
  logic                      arst_n;
  wire                       ps2_clk_line;
  wire                       ps2_dat_line;
  wire                       ps2_clk_drive_low;
  wire                       ps2_dat_drive_low;
  wire                       oled_csn;
  wire                       oled_clk;
  wire                       oled_mosi;
  wire                       oled_dc;
  wire                       oled_resn;
  mouse_oled_pkg::buttons_t  buttons;
  mouse_oled_pkg::cursor_x_t cursor_x;
  mouse_oled_pkg::cursor_y_t cursor_y;

  // Stimulus table: three packet bytes, a parity-corruption flag, expected buttons.
  mouse_oled_pkg::byte_t     row_b0 [NUM_ROWS];
  mouse_oled_pkg::byte_t     row_b1 [NUM_ROWS];
  mouse_oled_pkg::byte_t     row_b2 [NUM_ROWS];
  logic                      row_corrupt [NUM_ROWS];
  mouse_oled_pkg::buttons_t  row_buttons [NUM_ROWS];
  mouse_oled_pkg::byte_t     init_expected [mouse_oled_pkg::INIT_LENGTH];

  int                        exp_x = 0;
  int                        exp_y = 0;
  int                        main_errors = 0;
  int                        init_errors = 0;
  int                        frame_errors = 0;
  int                        tests_run = 0;
  int                        tests_failed = 0;
  int                        cycle_count = 0;
  int                        spi_count = 0;
  int                        spi_bits = 0;
  mouse_oled_pkg::byte_t     spi_shift = '0;
  mouse_oled_pkg::byte_t     pixel_high = '0;
  logic                      frame_request = 1'b0;
  logic                      frame_active = 1'b0;
  logic                      frame_done = 1'b0;

  initial $readmemh("design/oled_init.mem", init_expected);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  mouse_oled_top dut (
    .clk               (clk),
    .arst_n            (arst_n),
    .ps2_clk_in        (ps2_clk_line),
    .ps2_dat_in        (ps2_dat_line),
    .ps2_clk_drive_low (ps2_clk_drive_low),
    .ps2_dat_drive_low (ps2_dat_drive_low),
    .oled_csn          (oled_csn),
    .oled_clk          (oled_clk),
    .oled_mosi         (oled_mosi),
    .oled_dc           (oled_dc),
    .oled_resn         (oled_resn),
    .buttons           (buttons),
    .cursor_x          (cursor_x),
    .cursor_y          (cursor_y)
  );

  ps2_mouse_model mouse (
    .clk          (clk),
    .host_clk_low (ps2_clk_drive_low),
    .host_dat_low (ps2_dat_drive_low),
    .ps2_clk      (ps2_clk_line),
    .ps2_dat      (ps2_dat_line)
  );

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic set_row(input int idx, input logic [7:0] b0, input logic [7:0] b1,
                         input logic [7:0] b2, input logic corrupt, input logic [2:0] btn);
    row_b0[idx]      = b0;
    row_b1[idx]      = b1;
    row_b2[idx]      = b2;
    row_corrupt[idx] = corrupt;
    row_buttons[idx] = btn;
  endtask

  task automatic report_test(input string name, input int errors);
    tests_run++;
    if (errors == 0)
      $display("Test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("Test %s: %0d error(s)", name, errors);
    end
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Run stopped after %0d cycles before all tests finished", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  // SPI monitor. Bits are taken in the middle of each oled_clk high phase.
  always @(negedge clk)
  begin
    mouse_oled_pkg::byte_t  byte_value;
    mouse_oled_pkg::pixel_t word;
    mouse_oled_pkg::pixel_t expected_word;
    int                     pix_index;
    int                     word_index;
    int                     col;
    int                     row;

    if (arst_n && oled_clk)
    begin
      byte_value = {spi_shift[6:0], oled_mosi};  // MSB first.
      spi_shift  = byte_value;
      spi_bits++;
      if (spi_bits == 8)
      begin
        spi_bits = 0;
        if (spi_count < mouse_oled_pkg::INIT_LENGTH)
        begin
          if (byte_value !== init_expected[spi_count])
          begin
            $display("Fail oled_mosi init byte %0d: expected 0x%h, got 0x%h", spi_count,
                     init_expected[spi_count], byte_value);
            init_errors++;
          end
          if (oled_dc !== 1'b0)
          begin
            $display("Fail oled_dc at init byte %0d: expected 0x0, got 0x%h", spi_count, oled_dc);
            init_errors++;
          end
          if (oled_resn !== 1'b1 || oled_csn !== 1'b0)
          begin
            $display("Fail oled_resn/oled_csn at init byte %0d: expected 0x1/0x0, got 0x%h/0x%h",
                     spi_count, oled_resn, oled_csn);
            init_errors++;
          end
          if (spi_count == mouse_oled_pkg::INIT_LENGTH - 1)
            report_test("panel reset and init", init_errors);
        end
        else
        begin
          pix_index = spi_count - mouse_oled_pkg::INIT_LENGTH;
          if (frame_request && !frame_active && !frame_done && pix_index % FRAME_BYTES == 0)
            frame_active = 1'b1;
          if (frame_active)
          begin
            if (oled_dc !== 1'b1)
            begin
              $display("Fail oled_dc at pixel byte %0d: expected 0x1, got 0x%h", pix_index, oled_dc);
              frame_errors++;
            end
            if (pix_index % 2 == 0)
              pixel_high = byte_value;
            else
            begin
              word       = {pixel_high, byte_value};
              word_index = (pix_index % FRAME_BYTES) / 2;
              col        = word_index % mouse_oled_pkg::OLED_WIDTH;
              row        = word_index / mouse_oled_pkg::OLED_WIDTH;
              expected_word = (col == exp_x || row == exp_y) ? mouse_oled_pkg::COLOR_LINE
                                                             : mouse_oled_pkg::COLOR_BACKGROUND;
              if (word !== expected_word)
              begin
                $display("Fail oled_mosi pixel row %0d col %0d: expected 0x%h, got 0x%h", row,
                         col, expected_word, word);
                frame_errors++;
              end
              if (word_index == FRAME_WORDS - 1)
              begin
                frame_active = 1'b0;
                frame_done   = 1'b1;
                report_test("crosshair frame", frame_errors);
              end
            end
          end
        end
        spi_count++;
      end
    end
  end

  initial
  begin
    logic [7:0]  cmd_value;
    logic        cmd_ok;
    logic [31:0] rand_state;
    logic [7:0]  b0;
    int          r;
    int          errs;
    int          dx;
    int          dy;

    // Rows 5 to 8 cover discard, overflow, parity corruption and a second overflow.
    set_row(0, 8'h08, 8'h05, 8'h03, 1'b0, 3'b000);
    set_row(1, 8'h29, 8'h0A, 8'hF6, 1'b0, 3'b001);  // Negative dy wraps past 63.
    set_row(2, 8'h18, 8'hF1, 8'h00, 1'b0, 3'b000);
    set_row(3, 8'h18, 8'hF0, 8'h00, 1'b0, 3'b000);  // Column wraps below 0.
    set_row(4, 8'h0A, 8'h20, 8'h00, 1'b0, 3'b010);  // Column wraps past 127.
    set_row(5, 8'h04, 8'h01, 8'h02, 1'b0, 3'b010);
    set_row(6, 8'h4C, 8'h7F, 8'h7F, 1'b0, 3'b100);
    set_row(7, 8'h0B, 8'h03, 8'h04, 1'b1, 3'b011);
    set_row(8, 8'h8D, 8'h10, 8'h10, 1'b0, 3'b101);
    set_row(9, 8'h38, 8'h00, 8'hC0, 1'b0, 3'b000);
    rand_state = 32'd43638;
    for (r = FIXED_ROWS; r < NUM_ROWS; r++)
    begin
      rand_state = next_random(rand_state);
      b0 = {2'b00, rand_state[17:16], 1'b1, rand_state[22:20]};
      set_row(r, b0, rand_state[31:24], rand_state[15:8], 1'b0, b0[2:0]);
    end

    arst_n = 1'b0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    if (oled_resn !== 1'b0)
    begin
      $display("Fail oled_resn after reset: expected 0x0, got 0x%h", oled_resn);
      init_errors++;
    end

    errs = main_errors;
    mouse.receive_command(cmd_value, cmd_ok);
    if (cmd_value !== mouse_oled_pkg::CMD_ENABLE_REPORTING)
    begin
      $display("Fail ps2_dat command byte: expected 0x%h, got 0x%h",
               mouse_oled_pkg::CMD_ENABLE_REPORTING, cmd_value);
      main_errors++;
    end
    if (!cmd_ok)
    begin
      $display("The command frame had a wrong parity or stop bit");
      main_errors++;
    end
    // A packet before the acknowledge must be ignored.
    mouse.send_byte(8'h09, 1'b0);
    mouse.send_byte(8'h10, 1'b0);
    mouse.send_byte(8'h10, 1'b0);
    if (buttons !== 3'b000 || cursor_x !== 7'd0 || cursor_y !== 6'd0)
    begin
      $display("Fail buttons/cursor_x/cursor_y before ack: expected 0x0/0x00/0x00, got 0x%h/0x%h/0x%h",
               buttons, cursor_x, cursor_y);
      main_errors++;
    end
    mouse.send_byte(mouse_oled_pkg::RESP_ACK, 1'b0);
    report_test("command and acknowledge", main_errors - errs);

    for (r = 0; r < NUM_ROWS; r++)
    begin
      errs = main_errors;
      mouse.send_byte(row_b0[r], 1'b0);
      if (row_corrupt[r])
        mouse.send_byte(~row_b1[r], 1'b1);  // Junk byte that the line must drop.
      mouse.send_byte(row_b1[r], 1'b0);
      mouse.send_byte(row_b2[r], 1'b0);
      // Nine-bit signed moves, x modulo 128 and y modulo 64 with y growing downward.
      if (row_b0[r][3] && !row_b0[r][6] && !row_b0[r][7])
      begin
        dx    = row_b0[r][4] ? int'(row_b1[r]) - 256 : int'(row_b1[r]);
        dy    = row_b0[r][5] ? int'(row_b2[r]) - 256 : int'(row_b2[r]);
        exp_x = ((exp_x + dx) % 128 + 128) % 128;
        exp_y = ((exp_y - dy) % 64 + 64) % 64;
      end
      if (buttons !== row_buttons[r])
      begin
        $display("Fail buttons row %0d: expected 0x%h, got 0x%h", r, row_buttons[r], buttons);
        main_errors++;
      end
      if (cursor_x !== exp_x[6:0])
      begin
        $display("Fail cursor_x row %0d: expected 0x%h, got 0x%h", r, exp_x[6:0], cursor_x);
        main_errors++;
      end
      if (cursor_y !== exp_y[5:0])
      begin
        $display("Fail cursor_y row %0d: expected 0x%h, got 0x%h", r, exp_y[5:0], cursor_y);
        main_errors++;
      end
      report_test($sformatf("packet row %0d", r), main_errors - errs);
    end

    frame_request = 1'b1;
    wait (frame_done);
    @(negedge clk);

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
             main_errors + init_errors + frame_errors);
    if (tests_failed == 0 && main_errors + init_errors + frame_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/ps2_mouse_model.sv
`timescale 1ns/1ns
`default_nettype none

// Behavioral PS/2 mouse. Each bit lasts 16 system clocks, 8 high and 8 low.
module ps2_mouse_model (
  input  wire clk,
  input  wire host_clk_low,  // The DUT pulls the clock line low.
  input  wire host_dat_low,
  output wire ps2_clk,
  output wire ps2_dat
);

  logic clk_release = 1'b1;
  logic dat_release = 1'b1;

  // Open-drain lines with pull-ups, so either side can pull a line low.
  assign ps2_clk = clk_release & ~host_clk_low;
  assign ps2_dat = dat_release & ~host_dat_low;

  task automatic wait_clocks(input int count);
    repeat (count) @(negedge clk);
  endtask

  // One device-to-host frame, optionally with the parity bit inverted.
  task automatic send_byte(input logic [7:0] value, input logic bad_parity);
    logic [10:0] frame;
    int          i;

    frame = {1'b1, ~^value ^ bad_parity, value, 1'b0};  // Stop, odd parity, data, start.
    for (i = 0; i < 11; i++)
    begin
      @(negedge clk);
      dat_release = frame[i];
      wait_clocks(7);
      clk_release = 1'b0;
      wait_clocks(8);
      clk_release = 1'b1;
    end
    dat_release = 1'b1;
    wait_clocks(16);  // Idle gap between frames.
  endtask

  // Host-to-device command. The device clocks it in and answers with an ack bit.
  task automatic receive_command(output logic [7:0] value, output logic frame_ok);
    logic [9:0] bits;
    int         i;

    wait (host_clk_low === 1'b1);
    wait (host_clk_low === 1'b0 && host_dat_low === 1'b1);  // Request to send.
    wait_clocks(20);
    for (i = 0; i < 10; i++)
    begin
      clk_release = 1'b0;
      wait_clocks(8);
      clk_release = 1'b1;
      wait_clocks(4);
      bits[i] = ps2_dat;  // Host data is settled in the high half.
      wait_clocks(4);
    end
    // Ack bit: data low across one more clock pulse.
    dat_release = 1'b0;
    wait_clocks(4);
    clk_release = 1'b0;
    wait_clocks(8);
    clk_release = 1'b1;
    wait_clocks(8);
    dat_release = 1'b1;
    value    = bits[7:0];
    frame_ok = (^bits[8:0] == 1'b1) && bits[9];
  endtask

endmodule

`default_nettype wire

//--- design/mouse_oled_top.sv
`timescale 1ns/1ns
`default_nettype none

// PS/2 mouse drives a crosshair on a 96x64 SPI OLED.
module mouse_oled_top (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire                        ps2_clk_in,
  input  wire                        ps2_dat_in,
  output wire                        ps2_clk_drive_low,  // High pulls the line low.
  output wire                        ps2_dat_drive_low,
  output wire                        oled_csn,
  output wire                        oled_clk,
  output wire                        oled_mosi,
  output wire                        oled_dc,
  output wire                        oled_resn,
  output mouse_oled_pkg::buttons_t   buttons,
  output mouse_oled_pkg::cursor_x_t  cursor_x,
  output mouse_oled_pkg::cursor_y_t  cursor_y
);

  ps2_byte_if link ();

  ps2_line_ctrl u_line (
    .clk               (clk),
    .arst_n            (arst_n),
    .ps2_clk_in        (ps2_clk_in),
    .ps2_dat_in        (ps2_dat_in),
    .ps2_clk_drive_low (ps2_clk_drive_low),
    .ps2_dat_drive_low (ps2_dat_drive_low),
    .link              (link.line)
  );

  mouse_packet_decoder u_decoder (
    .clk      (clk),
    .arst_n   (arst_n),
    .link     (link.host),
    .buttons  (buttons),
    .cursor_x (cursor_x),
    .cursor_y (cursor_y)
  );

  // The streamer reads the cursor straight from the decoder outputs.
  oled_frame_streamer u_streamer (
    .clk       (clk),
    .arst_n    (arst_n),
    .cursor_x  (cursor_x),
    .cursor_y  (cursor_y),
    .oled_csn  (oled_csn),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi),
    .oled_dc   (oled_dc),
    .oled_resn (oled_resn)
  );

endmodule

`default_nettype wire

//--- design/oled_frame_streamer.sv
`timescale 1ns/1ns
`default_nettype none

module oled_frame_streamer (
  input  wire                        clk,
  input  wire                        arst_n,
  input  mouse_oled_pkg::cursor_x_t  cursor_x,
  input  mouse_oled_pkg::cursor_y_t  cursor_y,
  output logic                       oled_csn,
  output logic                       oled_clk,
  output logic                       oled_mosi,
  output logic                       oled_dc,
  output logic                       oled_resn
);

  typedef enum logic [1:0] {
    ST_RESET_PULSE,
    ST_INIT,
    ST_PIXELS
  } state_t;

  state_t                                      state;
  mouse_oled_pkg::byte_t                       init_rom [mouse_oled_pkg::INIT_LENGTH];
  logic [mouse_oled_pkg::OLED_RESET_WIDTH-1:0] reset_cnt;
  logic [mouse_oled_pkg::INIT_INDEX_WIDTH-1:0] init_idx;   // Next ROM byte to load.
  logic [3:0]                                  phase;      // Clock within the current byte.
  mouse_oled_pkg::byte_t                       cur_byte;
  logic                                        high_half;  // Next pixel byte is the high one.
  mouse_oled_pkg::cursor_x_t                   col;
  mouse_oled_pkg::cursor_y_t                   row;
  mouse_oled_pkg::cursor_x_t                   cx_q;
  mouse_oled_pkg::cursor_y_t                   cy_q;
  mouse_oled_pkg::cursor_x_t                   pix_cx;
  mouse_oled_pkg::cursor_y_t                   pix_cy;
  logic                                        frame_start;
  mouse_oled_pkg::pixel_t                      color;

  initial $readmemh("design/oled_init.mem", init_rom);

  // The first byte of a frame sees the live cursor, which is latched at the same time.
  assign frame_start = (col == '0) && (row == '0) && high_half;
  assign pix_cx      = frame_start ? cursor_x : cx_q;
  assign pix_cy      = frame_start ? cursor_y : cy_q;
  assign color       = (col == pix_cx || row == pix_cy) ? mouse_oled_pkg::COLOR_LINE
                                                        : mouse_oled_pkg::COLOR_BACKGROUND;

  // Each bit spans two clocks with the SPI clock high in the second.
  assign oled_clk  = (state != ST_RESET_PULSE) && phase[0];
  assign oled_mosi = cur_byte[3'd7 - phase[3:1]];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= ST_RESET_PULSE;
      reset_cnt <= '0;
      init_idx  <= '0;
      phase     <= '0;
      cur_byte  <= '0;
      high_half <= 1'b1;
      col       <= '0;
      row       <= '0;
      cx_q      <= '0;
      cy_q      <= '0;
      oled_csn  <= 1'b1;
      oled_dc   <= 1'b0;
      oled_resn <= 1'b0;
    end
    else if (state == ST_RESET_PULSE)
    begin
      reset_cnt <= reset_cnt + 1'b1;
      if (reset_cnt == mouse_oled_pkg::OLED_RESET_CYCLES - 1)
      begin
        oled_resn <= 1'b1;
        oled_csn  <= 1'b0;
        cur_byte  <= init_rom[0];
        init_idx  <= 1'b1;
        state     <= ST_INIT;
      end
    end
    else
    begin
      phase <= phase + 1'b1;
      if (phase == 4'd15)
      begin
        if (state == ST_INIT && init_idx != mouse_oled_pkg::INIT_LENGTH)
        begin
          cur_byte <= init_rom[init_idx];
          init_idx <= init_idx + 1'b1;
        end
        else
        begin
          state     <= ST_PIXELS;
          oled_dc   <= 1'b1;
          cur_byte  <= high_half ? color[15:8] : color[7:0];
          high_half <= ~high_half;
          if (frame_start)
          begin
            cx_q <= cursor_x;
            cy_q <= cursor_y;
          end
          // Advance after the low byte of each pixel.
          if (!high_half)
          begin
            if (col == mouse_oled_pkg::OLED_WIDTH - 1)
            begin
              col <= '0;
              if (row == mouse_oled_pkg::OLED_HEIGHT - 1)
                row <= '0;
              else
                row <= row + 1'b1;
            end
            else
              col <= col + 1'b1;
          end
        end
      end
    end
  end

  // The panel latches dc with the last bit, so it may only move at a byte boundary.
  dc_steady: assert property (@(posedge clk) disable iff (!arst_n)
    phase != 4'd0 |-> $stable(oled_dc));

endmodule

`default_nettype wire

//--- design/mouse_packet_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mouse_packet_decoder (
  input  wire                               clk,
  input  wire                               arst_n,
  ps2_byte_if.host                          link,
  output mouse_oled_pkg::buttons_t          buttons,
  output mouse_oled_pkg::cursor_x_t         cursor_x,
  output mouse_oled_pkg::cursor_y_t         cursor_y
);

  typedef enum logic [1:0] {
    ST_COMMAND,
    ST_COMMAND_ACK,
    ST_WAIT_RESPONSE,
    ST_PACKET
  } state_t;

  state_t                state;
  logic [1:0]            byte_idx;
  mouse_oled_pkg::byte_t pkt0;       // Flags and sign bits.
  mouse_oled_pkg::byte_t pkt1;       // Low eight bits of dx.
  logic                  byte_valid;
  logic [8:0]            dx;
  logic [8:0]            dy;
  logic [8:0]            sum_x;
  logic [8:0]            sum_y;

  // The byte is taken in the one cycle where request and ack overlap.
  assign byte_valid   = link.rx_req && link.rx_ack;
  assign link.tx_byte = mouse_oled_pkg::CMD_ENABLE_REPORTING;

  // Nine-bit two's complement moves. The third byte is used as it arrives.
  assign dx    = {pkt0[4], pkt1};
  assign dy    = {pkt0[5], link.rx_byte};
  assign sum_x = {2'b00, cursor_x} + dx;
  assign sum_y = {3'b000, cursor_y} - dy;  // Screen rows grow downward.

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state       <= ST_COMMAND;
      byte_idx    <= '0;
      pkt0        <= '0;
      pkt1        <= '0;
      link.rx_ack <= 1'b0;
      link.tx_req <= 1'b0;
      buttons     <= '0;
      cursor_x    <= '0;
      cursor_y    <= '0;
    end
    else
    begin
      link.rx_ack <= link.rx_req;

      case (state)
        ST_COMMAND:
        begin
          link.tx_req <= 1'b1;
          state       <= ST_COMMAND_ACK;
        end

        ST_COMMAND_ACK:
        begin
          if (link.tx_ack)
          begin
            link.tx_req <= 1'b0;
            state       <= ST_WAIT_RESPONSE;
          end
        end

        ST_WAIT_RESPONSE:
        begin
          if (byte_valid && link.rx_byte == mouse_oled_pkg::RESP_ACK)
          begin
            state    <= ST_PACKET;
            byte_idx <= '0;
          end
        end

        ST_PACKET:
        begin
          if (byte_valid)
          begin
            case (byte_idx)
              2'd0:
              begin
                // Bit 3 is always set in a first byte. Anything else is skipped.
                if (link.rx_byte[3])
                begin
                  pkt0     <= link.rx_byte;
                  byte_idx <= 2'd1;
                end
              end
              2'd1:
              begin
                pkt1     <= link.rx_byte;
                byte_idx <= 2'd2;
              end
              default:
              begin
                buttons  <= pkt0[2:0];
                byte_idx <= 2'd0;
                if (!pkt0[6] && !pkt0[7])  // An overflowed move is meaningless.
                begin
                  cursor_x <= sum_x[6:0];
                  cursor_y <= sum_y[5:0];
                end
              end
            endcase
          end
        end

        default:
          state <= ST_COMMAND;
      endcase
    end
  end

  // The line side may not lose a command that it has not acknowledged.
  tx_held: assert property (@(posedge clk) disable iff (!arst_n)
    link.tx_req && !link.tx_ack |=> link.tx_req);

endmodule

`default_nettype wire

//--- design/ps2_line_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_line_ctrl (
  input  wire         clk,
  input  wire         arst_n,
  input  wire         ps2_clk_in,
  input  wire         ps2_dat_in,
  output logic        ps2_clk_drive_low,
  output logic        ps2_dat_drive_low,
  ps2_byte_if.line    link
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RECEIVE,
    ST_INHIBIT,
    ST_REQUEST,
    ST_SEND,
    ST_WAIT_ACK
  } state_t;

  state_t                                     state;
  logic [1:0]                                 clk_sync;
  logic [1:0]                                 dat_sync;
  logic                                       clk_prev;
  logic                                       fall_q;     // One clock after a clock fall.
  logic [3:0]                                 bit_cnt;
  logic                                       parity;
  mouse_oled_pkg::byte_t                      rx_shift;
  logic [8:0]                                 tx_bits;    // Data with odd parity on top.
  logic [mouse_oled_pkg::PS2_TIMER_WIDTH-1:0] timer;
  logic                                       dat_s;

  assign dat_s = dat_sync[1];

  // Both lines idle high, so the synchronizers come out of reset at one.
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      clk_prev <= 1'b1;
      fall_q   <= 1'b0;
    end
    else
    begin
      clk_sync <= {clk_sync[0], ps2_clk_in};
      dat_sync <= {dat_sync[0], ps2_dat_in};
      clk_prev <= clk_sync[1];
      fall_q   <= clk_prev & ~clk_sync[1];
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state             <= ST_IDLE;
      bit_cnt           <= '0;
      parity            <= 1'b0;
      rx_shift          <= '0;
      tx_bits           <= '0;
      timer             <= '0;
      link.rx_req       <= 1'b0;
      link.rx_byte      <= '0;
      link.tx_ack       <= 1'b0;
      ps2_clk_drive_low <= 1'b0;
      ps2_dat_drive_low <= 1'b0;
    end
    else
    begin
      if (link.rx_req && link.rx_ack)
        link.rx_req <= 1'b0;
      if (link.tx_ack && !link.tx_req)
        link.tx_ack <= 1'b0;

      // Any device clock edge restarts the idle timer, except while we hold the clock.
      if (state == ST_IDLE || (fall_q && state != ST_INHIBIT))
        timer <= '0;
      else
        timer <= timer + 1'b1;

      if (state != ST_IDLE && state != ST_INHIBIT &&
          timer == mouse_oled_pkg::PS2_TIMEOUT_CYCLES - 1)
      begin
        // A stalled frame is abandoned and both lines are released.
        state             <= ST_IDLE;
        ps2_clk_drive_low <= 1'b0;
        ps2_dat_drive_low <= 1'b0;
      end
      else
      begin
        case (state)
          ST_IDLE:
          begin
            if (fall_q && !dat_s)
            begin
              state   <= ST_RECEIVE;  // Start bit seen.
              bit_cnt <= '0;
              parity  <= 1'b0;
            end
            else if (link.tx_req && !link.tx_ack)
            begin
              state             <= ST_INHIBIT;
              tx_bits           <= {~^link.tx_byte, link.tx_byte};
              ps2_clk_drive_low <= 1'b1;
            end
          end

          ST_RECEIVE:
          begin
            if (fall_q)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt < 4'd8)
                rx_shift <= {dat_s, rx_shift[7:1]};  // LSB arrives first.
              if (bit_cnt <= 4'd8)
                parity <= parity ^ dat_s;
              else
              begin
                // Stop bit. Keep the byte only if it is well framed and the slot is free.
                state <= ST_IDLE;
                if (dat_s && parity && !link.rx_req && !link.rx_ack)
                begin
                  link.rx_req  <= 1'b1;
                  link.rx_byte <= rx_shift;
                end
              end
            end
          end

          ST_INHIBIT:
          begin
            if (timer == mouse_oled_pkg::PS2_INHIBIT_CYCLES - 1)
            begin
              ps2_clk_drive_low <= 1'b0;
              ps2_dat_drive_low <= 1'b1;  // Data low is the request-to-send start bit.
              timer             <= '0;
              state             <= ST_REQUEST;
            end
          end

          ST_REQUEST:
          begin
            if (fall_q)
            begin
              ps2_dat_drive_low <= ~tx_bits[0];
              bit_cnt           <= 4'd1;
              state             <= ST_SEND;
            end
          end

          ST_SEND:
          begin
            if (fall_q)
            begin
              if (bit_cnt == 4'd9)
              begin
                ps2_dat_drive_low <= 1'b0;  // Released line is the stop bit.
                state             <= ST_WAIT_ACK;
              end
              else
              begin
                ps2_dat_drive_low <= ~tx_bits[bit_cnt];
                bit_cnt           <= bit_cnt + 1'b1;
              end
            end
          end

          ST_WAIT_ACK:
          begin
            // Without the ack the request is still open and the byte goes out again.
            if (fall_q)
            begin
              state <= ST_IDLE;
              if (!dat_s)
                link.tx_ack <= 1'b1;
            end
          end

          default:
            state <= ST_IDLE;
        endcase
      end
    end
  end

  // The decoder must see every byte before it is withdrawn.
  rx_held: assert property (@(posedge clk) disable iff (!arst_n)
    link.rx_req && !link.rx_ack |=> link.rx_req);

endmodule

`default_nettype wire

//--- design/ps2_byte_if.sv
`timescale 1ns/1ns
`default_nettype none

// Byte transport between the PS/2 line controller and the mouse decoder.
// Both directions use a four-phase req/ack handshake.
interface ps2_byte_if;

  logic                  rx_req;   // Received byte is waiting.
  logic                  rx_ack;
  mouse_oled_pkg::byte_t rx_byte;
  logic                  tx_req;   // Host wants a command byte sent.
  logic                  tx_ack;   // Device acknowledged the command.
  mouse_oled_pkg::byte_t tx_byte;

  modport line (
    output rx_req,
    output rx_byte,
    output tx_ack,
    input  rx_ack,
    input  tx_req,
    input  tx_byte
  );

  modport host (
    output rx_ack,
    output tx_req,
    output tx_byte,
    input  rx_req,
    input  rx_byte,
    input  tx_ack
  );

endinterface

`default_nettype wire

//--- design/mouse_oled_pkg.sv
`default_nettype none

package mouse_oled_pkg;

  // Widths with a meaning of their own.
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  cursor_x_t;
  typedef logic [5:0]  cursor_y_t;
  typedef logic [15:0] pixel_t;
  typedef logic [2:0]  buttons_t;  // Bit 0 is left, bit 1 right, bit 2 middle.

  // Panel geometry and power-up sequence.
  localparam int OLED_WIDTH        = 96;
  localparam int OLED_HEIGHT       = 64;
  localparam int INIT_LENGTH       = 18;  // Must match the byte count of oled_init.mem.
  localparam int OLED_RESET_CYCLES = 64;

  localparam int OLED_RESET_WIDTH = $clog2(OLED_RESET_CYCLES);
  localparam int INIT_INDEX_WIDTH = $clog2(INIT_LENGTH + 1);

  // Mouse protocol bytes.
  localparam byte_t CMD_ENABLE_REPORTING = 8'hF4;
  localparam byte_t RESP_ACK             = 8'hFA;

  // PS/2 line timing in system clocks.
  localparam int PS2_INHIBIT_CYCLES = 2500;
  localparam int PS2_TIMEOUT_CYCLES = 5000;
  localparam int PS2_TIMER_WIDTH    = $clog2(PS2_TIMEOUT_CYCLES);

  // Crosshair colors in RGB565.
  localparam pixel_t COLOR_LINE       = 16'hFFFF;
  localparam pixel_t COLOR_BACKGROUND = 16'h0000;

endpackage

`default_nettype wire
